//--- build.f
+incdir+hw
hw/lanePkg.sv
hw/laneEx1.sv
hw/laneEx2.sv
hw/laneEx3.sv
hw/scratchMem.sv
hw/laneExTop.sv
tb/laneExTb.sv

//--- tb/laneExTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random-stimulus testbench for the execute lane
// Model predicts writebacks and scratch memory contents
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "laneSettings.svh"

module laneExTb import lanePkg::*; ();

	localparam int TIMEOUT = 200;    // Max cycles for any wait
	localparam int NUM_OPS = 400;

	logic        clock = 1'b0;
	logic        rstN;
	logic        issueValid;
	issueT       issue;
	logic        exHold;
	logic        wbValid;
	wbT          wb;
	logic [31:0] rngState = 32'hfea7bb0d;
	xlenT        modelMem [`LANE_MEMDEPTH];    // Architectural memory copy
	wbT          expQ [$];                     // Expected writebacks in issue order

	laneExTop u_dut (
		.clock(clock), .rstN(rstN), .issueValid(issueValid), .issue(issue),
		.exHold(exHold), .wbValid(wbValid), .wb(wb)
	);

	always #4 clock = ~clock;    // 8 ns period

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic xlenT randomWord();
		return {nextRandom(), nextRandom()};
	endfunction

	function automatic xlenT signExtend(input logic [32:0] imm);
		return {{31{imm[32]}}, imm};
	endfunction

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Simulation stopped on first failure");
	endtask

	task automatic checkWb(input wbT got, input wbT exp);
		if (got !== exp) begin
			stopRun($sformatf("[ERROR] %0t: wb rn=%0d val=%h, expected rn=%0d val=%h",
				$time, got.rnId, got.value, exp.rnId, exp.value));
		end
	endtask

	task automatic checkIdle(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stopRun($sformatf("[ERROR] %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic checkLatency(input int got, input int exp);
		if (got != exp) begin
			stopRun($sformatf("[ERROR] %0t: retire after %0d edges, expected %0d",
				$time, got, exp));
		end
	endtask

	// Reference behavior applied in acceptance order
	task automatic applyModel(input issueT op);
		xlenT value;
		xlenT addr;
		logic writes;
		addr   = op.rsVal + signExtend(op.imm);    // Kept inside memory by stimulus
		value  = '0;
		writes = !op.flush && (op.rnId != `LANE_ZZR);
		case (op.op)
			opAdd:   value = op.rsVal + op.rtVal;
			opSub:   value = op.rsVal - op.rtVal;
			opAnd:   value = op.rsVal & op.rtVal;
			opXor:   value = op.rsVal ^ op.rtVal;
			opMovIr: value = signExtend(op.imm);
			opLdMr:  value = modelMem[addr];
			opStRm: begin
				writes = 1'b0;
				if (!op.flush)
					modelMem[addr] = op.rmVal;    // Flushed stores vanish
			end
			default: writes = 1'b0;    // Nop
		endcase
		if (writes)
			expQ.push_back(wbT'{rnId: op.rnId, value: value});
	endtask

	// Starts just after a rising edge and returns just after the accepting edge
	task automatic sendOp(input issueT op);
		int waited;
		waited     = 0;
		issue      = op;
		issueValid = 1'b1;
		@(negedge clock);
		while (exHold) begin    // Op stays stable under hold
			waited++;
			if (waited > TIMEOUT)
				stopRun("Timed out waiting for exHold to fall");
			@(negedge clock);
		end
		applyModel(op);    // Taken at the coming edge
		@(posedge clock);
		#1 issueValid = 1'b0;
	endtask

	function automatic issueT aluOp(input laneOpE kind, input regIdT rn, input xlenT a,
			input xlenT b, input logic flush);
		issueT op;
		op       = '0;
		op.flush = flush;
		op.op    = kind;
		op.rnId  = rn;
		op.rsVal = a;
		op.rtVal = b;
		op.imm   = 33'(randomWord());
		return op;
	endfunction

	// Splits a word address into base plus small signed displacement
	function automatic issueT memOp(input laneOpE kind, input int addr, input regIdT rn,
			input xlenT data, input logic flush);
		issueT op;
		int    offset;
		offset   = int'(nextRandom() % 64) - 32;
		op       = '0;
		op.flush = flush;
		op.op    = kind;
		op.rnId  = rn;
		op.rmVal = data;
		op.imm   = 33'(offset);
		op.rsVal = xlenT'(addr) - signExtend(op.imm);
		return op;
	endfunction

	function automatic issueT randomOp();
		logic [3:0] pick;
		logic       flush;
		regIdT      rn;
		int         addr;
		laneOpE     kind;
		pick  = 4'(nextRandom() % 16);
		flush = (nextRandom() % 8) == 0;    // About one in eight
		rn    = (nextRandom() % 8 == 0) ? `LANE_ZZR : regIdT'(nextRandom());
		addr  = (nextRandom() % 2) ? int'(nextRandom() % 64) : int'(nextRandom() % 8);
		if (pick < 2)    // Quarter are memory ops
			return memOp(opLdMr, addr, rn, randomWord(), flush);
		if (pick < 4)
			return memOp(opStRm, addr, rn, randomWord(), flush);
		case (pick)
			4, 5:    kind = opAdd;
			6, 7:    kind = opSub;
			8, 9:    kind = opAnd;
			10, 11:  kind = opXor;
			15:      kind = opNop;
			default: kind = opMovIr;
		endcase
		return aluOp(kind, rn, randomWord(), randomWord(), flush);
	endfunction

	// Writebacks are compared mid-cycle when outputs are settled
	always @(negedge clock) begin
		if (rstN && wbValid) begin
			if (expQ.size() == 0)
				stopRun($sformatf("Unexpected writeback to register %0d at %0t",
					wb.rnId, $time));
			else
				checkWb(wb, expQ.pop_front());
		end
	end

	initial begin
		int waited;
		int edges;
		rstN       = 1'b0;
		issueValid = 1'b0;
		issue      = '0;
		foreach (modelMem[i])
			modelMem[i] = '0;
		repeat (10) @(posedge clock);
		#1 rstN = 1'b1;
		checkIdle(exHold, 1'b0, "exHold after reset");
		checkIdle(wbValid, 1'b0, "wbValid after reset");

		// Lone add on an idle lane
		sendOp(aluOp(opAdd, 6'd5, 64'd40, 64'd2, 1'b0));
		edges = 1;    // Accepting edge counts as first
		@(negedge clock);
		while (!wbValid) begin
			if (edges > TIMEOUT)
				stopRun("Timed out waiting for the lone add to retire");
			@(posedge clock);
			edges++;
			@(negedge clock);
		end
		checkLatency(edges, 3);
		@(posedge clock);
		#1;

		sendOp(memOp(opLdMr, 63, 6'd1, '0, 1'b0));    // Never written
		sendOp(memOp(opStRm, 10, 6'd2, 64'hdead_beef_0123_4567, 1'b0));
		sendOp(memOp(opLdMr, 10, 6'd3, '0, 1'b0));    // Right behind the store
		sendOp(memOp(opStRm, 10, 6'd4, 64'h1111, 1'b1));    // Flushed store
		sendOp(memOp(opLdMr, 10, 6'd5, '0, 1'b0));    // Still the old word
		sendOp(aluOp(opXor, `LANE_ZZR, 64'h5, 64'h3, 1'b0));
		sendOp(aluOp(opNop, 6'd6, '0, '0, 1'b0));
		sendOp(aluOp(opAdd, 6'd7, 64'd1, 64'd1, 1'b1));

		for (int n = 0; n < NUM_OPS; n++) begin
			sendOp(randomOp());
			if (nextRandom() % 4 == 0) begin
				repeat (1 + nextRandom() % 3) @(posedge clock);    // Issue gap
				#1;
			end
		end

		waited = 0;
		while (expQ.size() != 0 || exHold) begin
			waited++;
			if (waited > TIMEOUT)
				stopRun("Timed out draining the lane");
			@(negedge clock);
		end
		repeat (20) @(negedge clock);    // Window for stray writebacks
		checkIdle(exHold, 1'b0, "exHold after drain");
		checkIdle(wbValid, 1'b0, "wbValid after drain");
		$display("All tests passed!");
		$finish;
	end

endmodule
`default_nettype wire

//--- hw/laneExTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane 2 execute back half, EX1..EX3
// plus scratch memory, testbench DUT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "laneSettings.svh"

module laneExTop import lanePkg::*; (
	input  logic  clock,
	input  logic  rstN,
	input  logic  issueValid,
	input  issueT issue,
	output logic  exHold,
	output logic  wbValid,
	output wbT    wb
);

	logic                  ex1Valid;
	ex1T                   ex1Op;
	logic                  ex2Valid;
	ex2T                   ex2Op;
	logic [`LANE_XLEN-1:0] loadData;    // EX2 to EX3 with load
	memReqT                memReq;
	logic                  memReqSig;
	logic                  memAck;
	logic [`LANE_XLEN-1:0] memRdata;

	laneEx1 uEx1 (
		.clock(clock), .rstN(rstN), .hold(exHold),
		.inValid(issueValid), .inOp(issue),
		.outValid(ex1Valid), .outOp(ex1Op)
	);

	laneEx2 uEx2 (
		.clock(clock), .rstN(rstN),
		.inValid(ex1Valid), .inOp(ex1Op), .exHold(exHold),
		.memReq(memReq), .memReqSig(memReqSig),
		.memAck(memAck), .memRdata(memRdata),
		.outValid(ex2Valid), .outOp(ex2Op), .loadData(loadData)
	);

	laneEx3 uEx3 (
		.clock(clock), .rstN(rstN),
		.inValid(ex2Valid), .inOp(ex2Op), .loadData(loadData),
		.wbValid(wbValid), .wb(wb)
	);

	scratchMem uMem (
		.clock(clock), .rstN(rstN),
		.memReq(memReq), .memReqSig(memReqSig),
		.memAck(memAck), .memRdata(memRdata)
	);

endmodule
`default_nettype wire

//--- hw/scratchMem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scratch data RAM, four-phase responder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "laneSettings.svh"

module scratchMem import lanePkg::*; (
	input  logic                  clock,
	input  logic                  rstN,
	input  memReqT                memReq,
	input  logic                  memReqSig,
	output logic                  memAck,
	output logic [`LANE_XLEN-1:0] memRdata
);

	logic [`LANE_XLEN-1:0] mem [`LANE_MEMDEPTH];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `LANE_MEMDEPTH; i++)
				mem[i] <= '0;    // Unwritten words read zero
			memAck   <= 1'b0;
			memRdata <= '0;
		end else if (memReqSig && !memAck) begin
			// New request, access then ack
			if (memReq.write)
				mem[memReq.addr] <= memReq.wdata;
			else
				memRdata <= mem[memReq.addr];
			memAck <= 1'b1;
		end else if (!memReqSig && memAck) begin
			memAck <= 1'b0;    // Req gone, close exchange
		end
	end

endmodule
`default_nettype wire

//--- hw/laneEx3.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EX3, result select and writeback reg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "laneSettings.svh"

module laneEx3 import lanePkg::*; (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  inValid,
	input  ex2T                   inOp,
	input  logic [`LANE_XLEN-1:0] loadData,
	output logic                  wbValid,
	output wbT                    wb
);

	logic [`LANE_XLEN-1:0] selValue;
	logic                  doWrite;

	// Forward by default, loads take the memory word
	assign selValue = (inOp.op == opLdMr) ? loadData : inOp.value;

	assign doWrite = inValid
		&& (inOp.rnId != `LANE_ZZR)                // ZZR sink
		&& !(inOp.op inside {opNop, opStRm});      // No dest

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= doWrite;    // One pulse per retire
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite) begin
			wb.rnId  <= inOp.rnId;
			wb.value <= selValue;
		end
	end

	// Anything reaching EX3 came from a legal issue encoding
	aOpLegal: assert property (@(posedge clock) disable iff (!rstN)
		inValid |-> inOp.op inside {opNop, opAdd, opSub, opAnd, opXor,
			opMovIr, opLdMr, opStRm});

endmodule
`default_nettype wire

//--- hw/laneEx2.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EX2, memory requester and lane hold
// Runs the req/ack exchange for ld/st
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "laneSettings.svh"

module laneEx2 import lanePkg::*; (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  inValid,
	input  ex1T                   inOp,
	output logic                  exHold,
	output memReqT                memReq,
	output logic                  memReqSig,
	input  logic                  memAck,
	input  logic [`LANE_XLEN-1:0] memRdata,
	output logic                  outValid,
	output ex2T                   outOp,
	output logic [`LANE_XLEN-1:0] loadData
);

	memStateE state;
	memStateE stateNext;
	logic     isMem;      // Ld or st waiting at EX2 input
	logic     memDone;    // Ack seen low, exchange over

	assign isMem   = inValid && (inOp.op == opLdMr || inOp.op == opStRm);
	assign memDone = (state == memReqLow) && !memAck;
	assign exHold  = isMem && !memDone;

	// Request fields come straight off EX1, which is frozen by the hold
	assign memReq.write = (inOp.op == opStRm);
	assign memReq.addr  = memAddrT'(inOp.result);    // Word address
	assign memReq.wdata = inOp.storeData;
	assign memReqSig    = (state == memReqHigh) || (state == memAckWait);

	always_comb begin
		stateNext = state;
		case (state)
			memIdle: begin
				if (isMem)
					stateNext = memReqHigh;    // Raise req next cycle
			end
			memReqHigh: stateNext = memAckWait;
			memAckWait: begin
				if (memAck)
					stateNext = memReqLow;     // Data taken, drop req
			end
			memReqLow: begin
				if (!memAck)
					stateNext = memIdle;
			end
			default: stateNext = memIdle;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state    <= memIdle;
			outValid <= 1'b0;
		end else begin
			state    <= stateNext;
			outValid <= inValid && !exHold;    // Bubble to EX3 while held
		end
	end

	always_ff @(posedge clock) begin
		outOp.op    <= inOp.op;
		outOp.rnId  <= inOp.rnId;
		outOp.value <= inOp.result;
		if (state == memAckWait && memAck)
			loadData <= memRdata;    // Held until the op leaves
	end

	// Req may only rise once the previous ack has cleared
	aReqAfterAck: assert property (@(posedge clock) disable iff (!rstN)
		$rose(memReqSig) |-> !memAck);

	aReqStable: assert property (@(posedge clock) disable iff (!rstN)
		memReqSig && $past(memReqSig) |-> $stable(memReq));

endmodule
`default_nettype wire

//--- hw/laneEx1.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First execute stage with flush squash and ALU
// Feeds EX2 with results or ld/st addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "laneSettings.svh"

module laneEx1 import lanePkg::*; (
	input  logic  clock,
	input  logic  rstN,
	input  logic  hold,        // Lane stall from EX2
	input  logic  inValid,
	input  issueT inOp,
	output logic  outValid,
	output ex1T   outOp
);

	logic [`LANE_XLEN-1:0] immExt;    // Sign-extended immediate
	logic [`LANE_XLEN-1:0] aguAddr;
	ex1T                   nextOp;

	assign immExt  = $signed(inOp.imm);    // Signed source extends
	assign aguAddr = inOp.rsVal + immExt;   // Base plus displacement

	always_comb begin
		nextOp.op        = inOp.op;
		nextOp.rnId      = inOp.rnId;
		nextOp.storeData = inOp.rmVal;     // Only meaningful for stores
		nextOp.result    = '0;

		if (inOp.flush) begin
			// Flushed ops still flow down the pipe as nops
			nextOp.op   = opNop;
			nextOp.rnId = `LANE_ZZR;
		end else begin
			case (inOp.op)
				opAdd:   nextOp.result = inOp.rsVal + inOp.rtVal;
				opSub:   nextOp.result = inOp.rsVal - inOp.rtVal;
				opAnd:   nextOp.result = inOp.rsVal & inOp.rtVal;
				opXor:   nextOp.result = inOp.rsVal ^ inOp.rtVal;
				opMovIr: nextOp.result = immExt;
				opLdMr,
				opStRm:  nextOp.result = aguAddr;    // Address for EX2
				default: nextOp.result = '0;         // Nop
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (!hold) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			outOp <= nextOp;    // Frozen while memory busy
		end
	end

	// A stall only ever freezes a live ld/st sitting at the EX2 input
	aHoldOnMem: assert property (@(posedge clock) disable iff (!rstN)
		hold |-> outValid && (outOp.op inside {opLdMr, opStRm}));

endmodule
`default_nettype wire

//--- hw/lanePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Op encodings and stage records for the lane
// Imported by every lane module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "laneSettings.svh"

package lanePkg;

	typedef enum logic [3:0] {
		opNop   = 4'd0,    // Bubble
		opAdd   = 4'd1,    // rn = rs + rt
		opSub   = 4'd2,    // rn = rs - rt
		opAnd   = 4'd3,    // rn = rs & rt
		opXor   = 4'd4,    // rn = rs ^ rt
		opMovIr = 4'd5,    // rn = imm
		opLdMr  = 4'd6,    // rn = mem[rs + imm]
		opStRm  = 4'd7     // mem[rs + imm] = rm
	} laneOpE;

	typedef enum logic [1:0] {
		memIdle, memReqHigh, memAckWait, memReqLow    // EX2 handshake phases
	} memStateE;

	typedef logic [`LANE_REGW-1:0] regIdT;
	typedef logic [`LANE_XLEN-1:0] xlenT;
	typedef logic [$clog2(`LANE_MEMDEPTH)-1:0] memAddrT;    // Word index

	typedef struct packed {
		logic        flush;    // Squash from branch unit
		laneOpE      op;
		regIdT       rsId, rtId, rmId, rnId;
		xlenT        rsVal, rtVal, rmVal;    // Operands ride along with op
		logic [32:0] imm;
	} issueT;

	typedef struct packed {
		laneOpE op;
		regIdT  rnId;
		xlenT   result;       // ALU value or memory address
		xlenT   storeData;    // rm for stores
	} ex1T;

	typedef struct packed {
		laneOpE op;
		regIdT  rnId;
		xlenT   value;    // Forwarded result
	} ex2T;

	typedef struct packed {
		logic    write;
		memAddrT addr;
		xlenT    wdata;
	} memReqT;

	typedef struct packed {
		regIdT rnId;
		xlenT  value;
	} wbT;

endpackage
`default_nettype wire

//--- hw/laneSettings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing macros for the execute lane
// Include before any file that needs the widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LANE_SETTINGS_SVH
`define LANE_SETTINGS_SVH

// Datapath width
`define LANE_XLEN 64

// Register id width, six bits covers the GPR space
`define LANE_REGW 6

// Scratch memory depth in words
`define LANE_MEMDEPTH 64

// Zero register, writes to it vanish
`define LANE_ZZR {`LANE_REGW{1'b1}}

`endif
